// ==== sources.f ====
+incdir+common
+incdir+tb
common/ddr_pkg.sv
design/rst_gen.sv
design/beat_fifo.sv
apb_regs/apb_cmd_regs.sv
ddr_rw/ddr_rw_engine.sv
ddr_rw/ddr_user_mem.sv
design/ddr_subsys_top.sv
tb/tb_ddr_subsys.sv

// ==== Bender.yml ====
package:
  name: ddr_subsys

export_include_dirs:
  - common

sources:
  # RTL in compile order
  - include_dirs:
      - common
    files:
      - common/ddr_pkg.sv
      - design/rst_gen.sv
      - design/beat_fifo.sv
      - apb_regs/apb_cmd_regs.sv
      - ddr_rw/ddr_rw_engine.sv
      - ddr_rw/ddr_user_mem.sv
      - design/ddr_subsys_top.sv

  # testbench
  - target: test
    include_dirs:
      - common
      - tb
    files:
      - tb/tb_ddr_subsys.sv

// ==== tb/ddr_ref_model.svh ====
// ddr memory reference model
// mirror of the word array plus beat push and drain helpers that keep it in step

localparam int MEM_WORDS  = 1 << `DDR_ADDR_W;
localparam int POP_TRIES  = 50;

ddr_pkg::ddr_beat_t ref_mem [MEM_WORDS];

// word address of beat idx with wraparound at the top of memory
function automatic int beat_addr(input int base, input int idx);
  return (base + idx) % MEM_WORDS;
endfunction

// start is refused while busy or with an empty length
function automatic bit start_rejected(input bit busy, input int len);
  return busy || (len == 0);
endfunction

// fresh random beats mirrored into the model as they are pushed
task automatic push_beats(input int base, input int len);
  ddr_pkg::ddr_beat_t beat;
  bit                 err;
  for (int i = 0; i < len; i++) begin
    beat = {$urandom, $urandom};
    ref_mem[beat_addr(base, i)] = beat;
    apb_write(ADDR_WDATA_LO, beat[31:0], err);
    apb_write(ADDR_WDATA_HI, beat[63:32], err);
    check("pslverr", err, 1'b0);
  end
endtask

// pop len beats and retry while the read FIFO is still empty
task automatic drain_beats(input int base, input int len);
  logic [31:0] lo;
  logic [31:0] hi;
  bit          err;
  int          tries;
  for (int i = 0; i < len; i++) begin
    err   = 1'b1;
    tries = 0;
    while (err && tries < POP_TRIES) begin
      apb_read(ADDR_RDATA_LO, lo, err);
      tries++;
    end
    if (err) begin
      $display("read beat %0d of the burst at 0x%0h never arrived", i, base);
      other_errors++;
      return;
    end
    apb_read(ADDR_RDATA_HI, hi, err);
    check("pslverr", err, 1'b0);
    check("rdata", {hi, lo}, ref_mem[beat_addr(base, i)]);
  end
endtask

// ==== tb/tb_ddr_subsys.sv ====
// ddr subsystem testbench
// APB driven bursts against a reference memory model, random stimulus

`timescale 1ns/1ns
`include "ddr_params.svh"

module tb_ddr_subsys;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 5;
  localparam int RAND_BURSTS = 50;
  localparam int NUM_BURSTS  = 4 + 2 + RAND_BURSTS + 3 + 4;
  localparam int WATCHDOG_CYCLES = NUM_BURSTS * (256 * 2 + 50) + 100;
  localparam int IDLE_POLLS  = 200;
  localparam logic [31:0] SEED = 32'h028c3cc1;

  localparam logic [7:0] ADDR_CTRL     = 8'h00;
  localparam logic [7:0] ADDR_BASE     = 8'h04;
  localparam logic [7:0] ADDR_LEN      = 8'h08;
  localparam logic [7:0] ADDR_STATUS   = 8'h0C;
  localparam logic [7:0] ADDR_WDATA_LO = 8'h10;
  localparam logic [7:0] ADDR_WDATA_HI = 8'h14;
  localparam logic [7:0] ADDR_RDATA_LO = 8'h18;
  localparam logic [7:0] ADDR_RDATA_HI = 8'h1C;

  // status bits from busy down to error
  localparam logic [31:0] ST_BUSY = 32'h4;
  localparam logic [31:0] ST_DONE = 32'h2;
  localparam logic [31:0] ST_ERR  = 32'h1;
  localparam bit DIR_WR = 1'b0;
  localparam bit DIR_RD = 1'b1;

  logic        clk_40M;
  logic        clk_40MHz_locked;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  int          check_count;
  int          mismatch_count;
  int          other_errors;

  `include "ddr_ref_model.svh"

  ddr_subsys_top DUT (
    .clk_40M          (clk_40M),
    .clk_40MHz_locked (clk_40MHz_locked),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr)
  );

  initial begin
    clk_40M = 1'b0;
    forever #(CLK_PERIOD / 2) clk_40M = ~clk_40M;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // ------------------------------
  // APB transfers
  // ------------------------------
  // setup and access phases then one idle cycle
  task automatic apb_xfer(input bit wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output bit err);
    @(negedge clk_40M);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk_40M);
    penable = 1'b1;
    #1;
    while (!pready) begin
      @(negedge clk_40M);
      #1;
    end
    // outputs sampled mid-cycle
    rdata = prdata;
    err   = pslverr;
    @(negedge clk_40M);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output bit err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output bit err);
    apb_xfer(1'b0, addr, 32'd0, data, err);
  endtask

  // ------------------------------
  // burst sequencing
  // ------------------------------
  task automatic program_burst(input int base, input int len);
    bit err;
    apb_write(ADDR_BASE, 32'(base), err);
    apb_write(ADDR_LEN, 32'(len), err);
  endtask

  task automatic start_burst(input bit rd, input bit exp_err);
    bit err;
    apb_write(ADDR_CTRL, {30'd0, rd, 1'b1}, err);
    check("pslverr", err, exp_err);
  endtask

  task automatic wait_idle(output logic [31:0] st);
    bit err;
    int polls;
    polls = 0;
    st    = ST_BUSY;
    while (st[2] && polls < IDLE_POLLS) begin
      apb_read(ADDR_STATUS, st, err);
      polls++;
    end
    if (st[2]) begin
      $display("busy never cleared after %0d status polls", polls);
      other_errors++;
    end
  endtask

  // hold keeps the host away from the FIFOs for a while after start
  task automatic run_burst(input bit rd, input int base, input int len, input int hold);
    logic [31:0] st;
    bit          err;
    program_burst(base, len);
    start_burst(rd, start_rejected(1'b0, len));
    if (hold > 0) begin
      repeat (hold) @(negedge clk_40M);
      apb_read(ADDR_STATUS, st, err);
      check("status", st, ST_BUSY);
    end
    if (rd) begin
      drain_beats(base, len);
    end else begin
      push_beats(base, len);
    end
    wait_idle(st);
    check("status", st, ST_DONE);
  endtask

  initial begin
    logic [31:0] st;
    bit          err;
    int          len;
    int          base;
    int          n;
    clk_40MHz_locked = 1'b0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = 8'd0;
    pwdata           = 32'd0;
    check_count      = 0;
    mismatch_count   = 0;
    other_errors     = 0;
    void'($urandom(SEED));

    // pready held low until the internal reset ends
    repeat (RST_CYCLES) begin
      @(negedge clk_40M);
      check("pready", pready, 1'b0);
    end
    clk_40MHz_locked = 1'b1;
    for (int i = 0; i < `RST_CNT - 1; i++) begin
      @(negedge clk_40M);
      check("pready", pready, 1'b0);
    end
    n = 0;
    while (!pready && n < 4) begin
      @(negedge clk_40M);
      n++;
    end
    if (!pready) begin
      $display("pready never rose after the reset count");
      other_errors++;
    end
    apb_read(ADDR_STATUS, st, err);
    check("status", st, 32'd0);
    apb_read(ADDR_RDATA_HI, st, err);
    check("pslverr", err, 1'b1);

    // fill the whole memory so every later read has a known value
    for (int b = 0; b < MEM_WORDS; b += 256) begin
      run_burst(DIR_WR, b, 256, 0);
    end

    // write then read back one random range
    len  = 1 + ($urandom % 256);
    base = $urandom % MEM_WORDS;
    run_burst(DIR_WR, base, len, 0);
    run_burst(DIR_RD, base, len, 0);

    // short random bursts with every tenth one wrapping past the top address
    for (int i = 0; i < RAND_BURSTS; i++) begin
      if (i % 10 == 9) begin
        len  = 2 + ($urandom % 15);
        base = MEM_WORDS - 1 - ($urandom % (len - 1));
      end else begin
        len  = 1 + ($urandom % 16);
        base = $urandom % MEM_WORDS;
      end
      run_burst($urandom % 2, base, len, 0);
    end

    // read back-pressure and a write burst waiting on host data
    run_burst(DIR_RD, $urandom % MEM_WORDS, 40, 100);
    base = $urandom % MEM_WORDS;
    run_burst(DIR_WR, base, 12, 60);
    run_burst(DIR_RD, base, 12, 0);

    // illegal starts set the sticky error and a legal one clears it
    program_burst(100, 8);
    start_burst(DIR_WR, start_rejected(1'b0, 8));
    start_burst(DIR_WR, start_rejected(1'b1, 8));
    apb_read(ADDR_STATUS, st, err);
    check("status", st, ST_BUSY | ST_ERR);
    push_beats(100, 8);
    wait_idle(st);
    check("status", st, ST_DONE | ST_ERR);
    program_burst(200, 0);
    start_burst(DIR_WR, start_rejected(1'b0, 0));
    apb_read(ADDR_STATUS, st, err);
    check("status", st, ST_DONE | ST_ERR);
    run_burst(DIR_RD, 100, 8, 0);

    $display("summary: %0d checks, %0d mismatches, %0d other failures",
             check_count, mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== design/ddr_subsys_top.sv ====
// ddr test subsystem top
// APB command port, beat FIFOs, burst engine and memory model

`timescale 1ns/1ns
`include "ddr_params.svh"

module ddr_subsys_top (
  input  logic        clk_40M,
  input  logic        clk_40MHz_locked,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic                                 rst_n;
  logic                                 start;
  ddr_pkg::ddr_req_t                    req;
  ddr_pkg::ddr_status_t                 status;
  logic                                 eng_busy;
  logic                                 eng_done;
  // write beat path
  logic                                 wf_push;
  logic                                 wf_pop;
  logic                                 wf_empty;
  logic                                 wf_full;
  ddr_pkg::ddr_beat_t                   wf_wdata;
  ddr_pkg::ddr_beat_t                   wf_rdata;
  // read beat path
  logic                                 rf_push;
  logic                                 rf_pop;
  logic                                 rf_empty;
  ddr_pkg::ddr_beat_t                   rf_wdata;
  ddr_pkg::ddr_beat_t                   rf_rdata;
  logic [$clog2(`FIFO_DEPTH + 1)-1:0]   rf_free;
  // memory user port
  logic                                 mem_req_valid;
  ddr_pkg::mem_req_t                    mem_req;
  logic                                 mem_cmd_rdy;
  logic                                 mem_rd_valid;
  ddr_pkg::ddr_beat_t                   mem_rd_data;

  // error flag lives in the register block
  assign status = '{busy: eng_busy, done: eng_done, error: 1'b0};

  rst_gen rst_gen_inst (
    .clk_40M          (clk_40M),
    .clk_40MHz_locked (clk_40MHz_locked),
    .rst_n            (rst_n)
  );

  // ------------------------------
  // input side
  // ------------------------------
  apb_cmd_regs apb_cmd_regs_inst (
    .clk_40M  (clk_40M),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .start    (start),
    .req      (req),
    .status   (status),
    .wf_push  (wf_push),
    .wf_data  (wf_wdata),
    .wf_full  (wf_full),
    .rf_pop   (rf_pop),
    .rf_data  (rf_rdata),
    .rf_empty (rf_empty)
  );

  beat_fifo #(.T(ddr_pkg::ddr_beat_t)) wr_fifo_inst (
    .clk_40M (clk_40M),
    .rst_n   (rst_n),
    .push    (wf_push),
    .wdata   (wf_wdata),
    .pop     (wf_pop),
    .rdata   (wf_rdata),
    .empty   (wf_empty),
    .full    (wf_full),
    .free    ()
  );

  // ------------------------------
  // processing
  // ------------------------------
  ddr_rw_engine ddr_rw_engine_inst (
    .clk_40M       (clk_40M),
    .rst_n         (rst_n),
    .start         (start),
    .req           (req),
    .busy          (eng_busy),
    .done          (eng_done),
    .wf_pop        (wf_pop),
    .wf_data       (wf_rdata),
    .wf_empty      (wf_empty),
    .rf_push       (rf_push),
    .rf_data       (rf_wdata),
    .rf_free       (rf_free),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_cmd_rdy   (mem_cmd_rdy),
    .mem_rd_valid  (mem_rd_valid),
    .mem_rd_data   (mem_rd_data)
  );

  // ------------------------------
  // output side
  // ------------------------------
  ddr_user_mem ddr_user_mem_inst (
    .clk_40M       (clk_40M),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_cmd_rdy   (mem_cmd_rdy),
    .mem_rd_valid  (mem_rd_valid),
    .mem_rd_data   (mem_rd_data)
  );

  beat_fifo #(.T(ddr_pkg::ddr_beat_t)) rd_fifo_inst (
    .clk_40M (clk_40M),
    .rst_n   (rst_n),
    .push    (rf_push),
    .wdata   (rf_wdata),
    .pop     (rf_pop),
    .rdata   (rf_rdata),
    .empty   (rf_empty),
    .full    (),
    .free    (rf_free)
  );

endmodule

// ==== ddr_rw/ddr_user_mem.sv ====
// on-chip memory behind a controller-style user port
// fixed read latency pipeline and a short ready drop after every fourth request

`timescale 1ns/1ns
`include "ddr_params.svh"

module ddr_user_mem (
  input  logic               clk_40M,
  input  logic               rst_n,
  input  logic               mem_req_valid,
  input  ddr_pkg::mem_req_t  mem_req,
  output logic               mem_cmd_rdy,
  output logic               mem_rd_valid,
  output ddr_pkg::ddr_beat_t mem_rd_data
);

  localparam int DEPTH = 1 << `DDR_ADDR_W;
  localparam int LAT   = `MEM_RD_LAT;

  ddr_pkg::ddr_beat_t mem     [DEPTH];
  ddr_pkg::ddr_beat_t rd_pipe [LAT];
  logic [LAT-1:0]     vld_pipe;
  logic [1:0]         gap_cnt;
  logic               rdy_q;
  logic               accept;

  assign accept       = mem_req_valid && rdy_q;
  assign mem_cmd_rdy  = rdy_q;
  assign mem_rd_valid = vld_pipe[LAT-1];
  assign mem_rd_data  = rd_pipe[LAT-1];

  // array write and read pipeline data
  always_ff @(posedge clk_40M) begin
    if (accept && mem_req.wr) begin
      mem[mem_req.addr] <= mem_req.data;
    end
    rd_pipe[0] <= mem[mem_req.addr];
    for (int i = 1; i < LAT; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  // read valid pipeline
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[LAT-2:0], accept && !mem_req.wr};
    end
  end

  // one idle refresh cycle per four accepted requests
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      gap_cnt <= '0;
      rdy_q   <= 1'b1;
    end else if (!rdy_q) begin
      rdy_q <= 1'b1;
    end else if (accept) begin
      gap_cnt <= gap_cnt + 1'b1;
      if (gap_cnt == 2'd3) begin
        rdy_q <= 1'b0;
      end
    end
  end

endmodule

// ==== ddr_rw/ddr_rw_engine.sv ====
// burst engine
// splits one burst command into single-beat requests on the memory user port
// and tracks reads in flight for completion and read credit

`timescale 1ns/1ns
`include "ddr_params.svh"

module ddr_rw_engine (
  input  logic                                clk_40M,
  input  logic                                rst_n,
  input  logic                                start,
  input  ddr_pkg::ddr_req_t                   req,
  output logic                                busy,
  output logic                                done,
  output logic                                wf_pop,
  input  ddr_pkg::ddr_beat_t                  wf_data,
  input  logic                                wf_empty,
  output logic                                rf_push,
  output ddr_pkg::ddr_beat_t                  rf_data,
  input  logic [$clog2(`FIFO_DEPTH + 1)-1:0]  rf_free,
  output logic                                mem_req_valid,
  output ddr_pkg::mem_req_t                   mem_req,
  input  logic                                mem_cmd_rdy,
  input  logic                                mem_rd_valid,
  input  ddr_pkg::ddr_beat_t                  mem_rd_data
);

  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  ddr_pkg::ddr_req_t      cmd_q;
  logic [`DDR_ADDR_W-1:0] addr_q;
  logic [`DDR_LEN_W-1:0]  issued_q;
  logic [`DDR_LEN_W-1:0]  returned_q;
  logic [`DDR_LEN_W-1:0]  last_idx;
  logic [CNT_W-1:0]       inflight_q;
  logic                   is_rd;
  logic                   more;
  logic                   fire;
  logic                   rd_fire;
  logic                   last_issue;
  logic                   last_return;

  // ------------------------------
  // issue side
  // ------------------------------
  assign is_rd    = (cmd_q.dir == ddr_pkg::DDR_READ);
  assign more     = (issued_q != cmd_q.len);
  assign last_idx = cmd_q.len - 1'b1;

  // writes wait for host data, reads wait for room in the read FIFO
  assign mem_req_valid = busy && more && (is_rd ? (rf_free > inflight_q) : !wf_empty);

  assign fire    = mem_req_valid && mem_cmd_rdy;
  assign rd_fire = fire && is_rd;
  assign wf_pop  = fire && !is_rd;

  assign mem_req = '{wr: !is_rd, addr: addr_q, data: (is_rd ? '0 : wf_data)};

  // ------------------------------
  // return side
  // ------------------------------
  assign rf_push = mem_rd_valid;
  assign rf_data = mem_rd_data;

  assign last_issue  = fire && (issued_q == last_idx);
  assign last_return = mem_rd_valid && (returned_q == last_idx);

  // reads accepted but not yet back
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      inflight_q <= '0;
    end else begin
      case ({rd_fire, mem_rd_valid})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: ;
      endcase
    end
  end

  // burst sequencing
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      cmd_q      <= '0;
      addr_q     <= '0;
      issued_q   <= '0;
      returned_q <= '0;
      busy       <= 1'b0;
      done       <= 1'b0;
    end else if (start && !busy) begin
      cmd_q      <= req;
      addr_q     <= req.base;
      issued_q   <= '0;
      returned_q <= '0;
      busy       <= 1'b1;
      done       <= 1'b0;
    end else if (busy) begin
      if (fire) begin
        // wraps modulo the memory depth
        addr_q   <= addr_q + 1'b1;
        issued_q <= issued_q + 1'b1;
      end
      if (mem_rd_valid) begin
        returned_q <= returned_q + 1'b1;
      end
      if ((!is_rd && last_issue) || (is_rd && last_return)) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

endmodule

// ==== apb_regs/apb_cmd_regs.sv ====
// APB command registers
// burst command, status readback and the 64-bit beat push/pop windows

`timescale 1ns/1ns
`include "ddr_params.svh"

module apb_cmd_regs (
  input  logic                 clk_40M,
  input  logic                 rst_n,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [7:0]           paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr,
  output logic                 start,
  output ddr_pkg::ddr_req_t    req,
  input  ddr_pkg::ddr_status_t status,
  output logic                 wf_push,
  output ddr_pkg::ddr_beat_t   wf_data,
  input  logic                 wf_full,
  output logic                 rf_pop,
  input  ddr_pkg::ddr_beat_t   rf_data,
  input  logic                 rf_empty
);

  localparam logic [7:0] ADDR_CTRL     = 8'h00;
  localparam logic [7:0] ADDR_BASE     = 8'h04;
  localparam logic [7:0] ADDR_LEN      = 8'h08;
  localparam logic [7:0] ADDR_STATUS   = 8'h0C;
  localparam logic [7:0] ADDR_WDATA_LO = 8'h10;
  localparam logic [7:0] ADDR_WDATA_HI = 8'h14;
  localparam logic [7:0] ADDR_RDATA_LO = 8'h18;
  localparam logic [7:0] ADDR_RDATA_HI = 8'h1C;

  logic [`DDR_ADDR_W-1:0] base_q;
  logic [`DDR_LEN_W-1:0]  len_q;
  logic [31:0]            wdata_lo_q;
  logic                   err_q;
  logic                   ready_q;
  logic                   access;
  logic                   wr_access;
  logic                   rd_access;
  logic                   start_err;
  ddr_pkg::ddr_status_t   status_rd;

  // ------------------------------
  // access decode
  // ------------------------------
  assign access    = psel && penable && ready_q;
  assign wr_access = access && pwrite;
  assign rd_access = access && !pwrite;
  assign start_err = status.busy || (len_q == '0);

  assign pready  = ready_q;
  assign wf_push = wr_access && (paddr == ADDR_WDATA_HI) && !wf_full;
  assign wf_data = {pwdata, wdata_lo_q};
  assign rf_pop  = rd_access && (paddr == ADDR_RDATA_HI) && !rf_empty;

  // engine flags plus the sticky error bit
  always_comb begin
    status_rd       = status;
    status_rd.error = err_q;
  end

  always_comb begin
    pslverr = 1'b0;
    if (access) begin
      case (paddr)
        ADDR_CTRL:     pslverr = pwrite && pwdata[0] && start_err;
        ADDR_WDATA_HI: pslverr = pwrite && wf_full;
        ADDR_RDATA_LO,
        ADDR_RDATA_HI: pslverr = !pwrite && rf_empty;
        default:       pslverr = 1'b0;
      endcase
    end
  end

  // read mux, zero wait states
  always_comb begin
    case (paddr)
      ADDR_CTRL:     prdata = {30'd0, req.dir == ddr_pkg::DDR_READ, 1'b0};
      ADDR_BASE:     prdata = 32'(base_q);
      ADDR_LEN:      prdata = 32'(len_q);
      ADDR_STATUS:   prdata = 32'(status_rd);
      ADDR_WDATA_LO: prdata = wdata_lo_q;
      ADDR_RDATA_LO: prdata = rf_data[31:0];
      ADDR_RDATA_HI: prdata = rf_data[63:32];
      default:       prdata = '0;
    endcase
  end

  // ------------------------------
  // command registers
  // ------------------------------
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
      base_q  <= '0;
      len_q   <= '0;
      err_q   <= 1'b0;
      start   <= 1'b0;
      req     <= '0;
    end else begin
      ready_q <= 1'b1;
      start   <= 1'b0;
      if (wr_access) begin
        case (paddr)
          ADDR_CTRL: begin
            if (pwdata[0] && start_err) begin
              err_q <= 1'b1;
            end else if (pwdata[0]) begin
              // legal start, latch the command for the engine
              err_q    <= 1'b0;
              start    <= 1'b1;
              req.dir  <= pwdata[1] ? ddr_pkg::DDR_READ : ddr_pkg::DDR_WRITE;
              req.base <= base_q;
              req.len  <= len_q;
            end
          end
          ADDR_BASE: base_q <= pwdata[`DDR_ADDR_W-1:0];
          ADDR_LEN:  len_q  <= pwdata[`DDR_LEN_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // low half of the next write beat
  always_ff @(posedge clk_40M) begin
    if (wr_access && (paddr == ADDR_WDATA_LO)) begin
      wdata_lo_q <= pwdata;
    end
  end

endmodule

// ==== design/beat_fifo.sv ====
// synchronous beat FIFO
// show-ahead head, occupancy counter gives the free count

`timescale 1ns/1ns
`include "ddr_params.svh"

module beat_fifo #(
  parameter type T     = logic [`DDR_DATA_W-1:0],
  parameter int  DEPTH = `FIFO_DEPTH
) (
  input  logic                         clk_40M,
  input  logic                         rst_n,
  input  logic                         push,
  input  T                             wdata,
  input  logic                         pop,
  output T                             rdata,
  output logic                         empty,
  output logic                         full,
  output logic [$clog2(DEPTH + 1)-1:0] free
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 buf_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign free  = CNT_W'(DEPTH) - count;
  assign rdata = buf_mem[rd_ptr];

  // storage
  always_ff @(posedge clk_40M) begin
    if (do_push) begin
      buf_mem[wr_ptr] <= wdata;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== design/rst_gen.sv ====
// internal reset generator
// holds rst_n low until the clock has been locked for RST_CNT cycles

`timescale 1ns/1ns
`include "ddr_params.svh"

module rst_gen (
  input  logic clk_40M,
  input  logic clk_40MHz_locked,
  output logic rst_n
);

  localparam int CNT_W = $clog2(`RST_CNT + 1);
  localparam logic [CNT_W-1:0] CNT_END = CNT_W'(`RST_CNT);

  logic [CNT_W-1:0] lock_cnt;

  // saturating count of locked cycles
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      lock_cnt <= '0;
    end else if (lock_cnt < CNT_END) begin
      lock_cnt <= lock_cnt + 1'b1;
    end
  end

  // release lands on the edge where the count completes
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      rst_n <= 1'b0;
    end else begin
      rst_n <= (lock_cnt >= CNT_END - 1'b1);
    end
  end

endmodule

// ==== common/ddr_pkg.sv ====
// ddr test platform types
// burst command, memory request, beat and status

`include "ddr_params.svh"

package ddr_pkg;

  // burst direction
  typedef enum logic [1:0] {
    DDR_WRITE = 2'd0,
    DDR_READ  = 2'd1
  } ddr_cmd_e;

  // burst command from registers to engine
  typedef struct packed {
    ddr_cmd_e                dir;
    logic [`DDR_ADDR_W-1:0]  base;
    logic [`DDR_LEN_W-1:0]   len;
  } ddr_req_t;

  // one request on the memory user port
  typedef struct packed {
    logic                    wr;
    logic [`DDR_ADDR_W-1:0]  addr;
    logic [`DDR_DATA_W-1:0]  data;
  } mem_req_t;

  // one data beat
  typedef logic [`DDR_DATA_W-1:0] ddr_beat_t;

  // status as seen by the host, error is sticky in the registers
  typedef struct packed {
    logic busy;
    logic done;
    logic error;
  } ddr_status_t;

endpackage

// ==== common/ddr_params.svh ====
// ddr test platform parameters
// widths, depths, memory latency and reset hold count

`ifndef DDR_PARAMS_SVH
`define DDR_PARAMS_SVH

// beat and address geometry
`define DDR_DATA_W 64
`define DDR_ADDR_W 10
`define DDR_LEN_W  9

// beat fifo depth, same for write and read side
`define FIFO_DEPTH 16

// memory read pipeline depth
`define MEM_RD_LAT 3

// locked cycles before internal reset release
`define RST_CNT    20

`endif
